/* source/riscboy_defines.svh */
`ifndef RISCBOY_DEFINES_SVH
`define RISCBOY_DEFINES_SVH

// SRAM geometry, 256K x 16
`define W_SRAM_ADDR  18
`define W_SRAM_DATA  16
`define W_SRAM_BYTES (`W_SRAM_DATA / 8)

// Cycles of system reset after the synchroniser
// Board build uses 200
`define RESET_COUNT  16

// Bit positions in the pad vector and on the LEDs
`define N_PADS       5
`define PIN_DPAD_U   4
`define PIN_DPAD_D   3
`define PIN_DPAD_L   2
`define PIN_DPAD_R   1
`define PIN_BTN_A    0

`endif

/* source/sram_pkg.sv */
`default_nettype none
`include "riscboy_defines.svh"

package sram_pkg;

// Command from the core, byte_n is active low per lane
typedef struct packed {
	logic                     write;
	logic [`W_SRAM_ADDR-1:0]  addr;
	logic [`W_SRAM_DATA-1:0]  wdata;
	logic [`W_SRAM_BYTES-1:0] byte_n;
} sram_cmd_t;

typedef struct packed {
	logic [`W_SRAM_DATA-1:0] rdata;
} sram_rsp_t;

// Controller to PHY, one cycle ahead of the pins
typedef struct packed {
	logic [`W_SRAM_ADDR-1:0]  addr;
	logic [`W_SRAM_DATA-1:0]  dq_out;
	logic [`W_SRAM_DATA-1:0]  dq_oe;
	logic                     we_n;
	logic                     oe_n;
	logic                     ce_n;
	logic [`W_SRAM_BYTES-1:0] byte_n;
} sram_phy_ctrl_t;

typedef enum logic [2:0] {
	IDLE, WR_SETUP, WR_STROBE, WR_HOLD, RD_ENABLE, RD_WAIT, RD_CAPTURE
} sram_state_e;

endpackage

`default_nettype wire

/* source/board_pkg.sv */
`default_nettype none

package board_pkg;

// Synchronised pad levels
// Field order matches the PIN_* bit positions
typedef struct packed {
	logic dpad_u;
	logic dpad_d;
	logic dpad_l;
	logic dpad_r;
	logic btn_a;
} pad_sample_t;

typedef enum logic [1:0] {
	SYNC,
	COUNT,
	RUN
} rst_state_e;

endpackage

`default_nettype wire

/* source/fpga_reset.sv */
`timescale 1ns/10ps
`default_nettype none

module fpga_reset import board_pkg::*; #(
	parameter SHIFT = 2,
	parameter COUNT = 16
) (
	input  wire clk_sys,
	input  wire force_rst_n,
	output wire rst_n
);

localparam int W_CNT = $clog2(COUNT + 1);

logic [SHIFT-1:0] sync_q;
logic [W_CNT-1:0] cnt_q;
rst_state_e       state_q;
logic             rst_q;

// Assert at once, release through the shift register
always_ff @(posedge clk_sys or negedge force_rst_n) begin
	if (!force_rst_n) begin
		sync_q <= '0;
		cnt_q <= '0;
		state_q <= SYNC;
		rst_q <= 1'b0;
	end else begin
		sync_q <= (sync_q << 1) | SHIFT'(1);
		case (state_q)
		SYNC: if (sync_q[SHIFT-1]) begin
			state_q <= board_pkg::COUNT;
			cnt_q <= W_CNT'(1);
		end
		board_pkg::COUNT: if (cnt_q == W_CNT'(COUNT - 1)) begin
			state_q <= RUN;
			rst_q <= 1'b1;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
		RUN: rst_q <= 1'b1;
		default: state_q <= SYNC;
		endcase
	end
end

assign rst_n = rst_q;

endmodule

`default_nettype wire

/* source/sram_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscboy_defines.svh"

module sram_ctrl import sram_pkg::*; #(
	// Cycles spent in the read wait state
	parameter RD_WAIT = 2
) (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire                    cmd_valid,
	input  wire sram_cmd_t         cmd,
	output logic                   busy,
	output sram_phy_ctrl_t         phy_ctrl,
	input  wire [`W_SRAM_DATA-1:0] dq_in,
	output logic                   rsp_valid,
	output sram_rsp_t              rsp
);

localparam int W_WAIT = $clog2(RD_WAIT + 1);

sram_state_e       state_q;
sram_cmd_t         cmd_q;
logic [W_WAIT-1:0] wait_q;

wire accept = cmd_valid && !busy;

// ########################################################################
// Sequencer

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		state_q <= IDLE;
		busy <= 1'b1;
		rsp_valid <= 1'b0;
		wait_q <= '0;
	end else begin
		rsp_valid <= 1'b0;
		case (state_q)
		IDLE: begin
			busy <= accept;
			if (accept)
				state_q <= cmd.write ? WR_SETUP : RD_ENABLE;
		end
		WR_SETUP: state_q <= WR_STROBE;
		WR_STROBE: state_q <= WR_HOLD;
		// busy drops one cycle later, once the hold is on the pins
		WR_HOLD: state_q <= IDLE;
		RD_ENABLE: begin
			state_q <= sram_pkg::RD_WAIT;
			wait_q <= '0;
		end
		sram_pkg::RD_WAIT: begin
			if (wait_q == W_WAIT'(RD_WAIT - 1))
				state_q <= RD_CAPTURE;
			else
				wait_q <= wait_q + 1'b1;
		end
		RD_CAPTURE: begin
			state_q <= IDLE;
			busy <= 1'b0;
			rsp_valid <= 1'b1;
		end
		default: state_q <= IDLE;
		endcase
	end
end

always_ff @(posedge clk_sys) begin
	if (accept)
		cmd_q <= cmd;
	if (state_q == RD_CAPTURE)
		rsp.rdata <= dq_in;
end

// ########################################################################
// Pin controls, registered again in the PHY

always_comb begin
	phy_ctrl.addr = cmd_q.addr;
	phy_ctrl.dq_out = cmd_q.wdata;
	phy_ctrl.dq_oe = '0;
	phy_ctrl.we_n = 1'b1;
	phy_ctrl.oe_n = 1'b1;
	phy_ctrl.ce_n = 1'b1;
	phy_ctrl.byte_n = '1;
	case (state_q)
	WR_SETUP, WR_STROBE, WR_HOLD: begin
		phy_ctrl.ce_n = 1'b0;
		phy_ctrl.byte_n = cmd_q.byte_n;
		phy_ctrl.we_n = state_q != WR_STROBE;
		// Data stays driven through the hold after we_n rises
		phy_ctrl.dq_oe = {`W_SRAM_DATA{state_q != WR_SETUP}};
	end
	RD_ENABLE, sram_pkg::RD_WAIT, RD_CAPTURE: begin
		phy_ctrl.ce_n = 1'b0;
		phy_ctrl.oe_n = 1'b0;
		phy_ctrl.byte_n = '0;
	end
	default: begin
		phy_ctrl.ce_n = 1'b1;
	end
	endcase
end

endmodule

`default_nettype wire

/* source/async_sram_phy.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscboy_defines.svh"

module async_sram_phy import sram_pkg::*; #(
	parameter W_ADDR     = `W_SRAM_ADDR,
	parameter W_DATA     = `W_SRAM_DATA,
	parameter DQ_SYNC_IN = 1
) (
	input  wire                  clk_sys,
	input  wire                  rst_n,
	input  wire sram_phy_ctrl_t  ctrl,
	output wire [W_DATA-1:0]     dq_in,
	output wire [W_ADDR-1:0]     sram_addr,
	inout  wire [W_DATA-1:0]     sram_dq,
	output wire                  sram_we_n,
	output wire                  sram_oe_n,
	output wire                  sram_ce_n,
	output wire [W_DATA/8-1:0]   sram_byte_n
);

logic [W_ADDR-1:0]   addr_q;
logic [W_DATA-1:0]   dq_out_q;
logic [W_DATA-1:0]   dq_oe_q;
logic                we_n_q;
logic                oe_n_q;
logic                ce_n_q;
logic [W_DATA/8-1:0] byte_n_q;

// Strobes come out of reset inactive and the bus released
always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		addr_q <= '0;
		dq_oe_q <= '0;
		we_n_q <= 1'b1;
		oe_n_q <= 1'b1;
		ce_n_q <= 1'b1;
		byte_n_q <= '1;
	end else begin
		addr_q <= ctrl.addr;
		dq_oe_q <= ctrl.dq_oe;
		we_n_q <= ctrl.we_n;
		oe_n_q <= ctrl.oe_n;
		ce_n_q <= ctrl.ce_n;
		byte_n_q <= ctrl.byte_n;
	end
end

always_ff @(posedge clk_sys) begin
	dq_out_q <= ctrl.dq_out;
end

genvar i;
generate
for (i = 0; i < W_DATA; i = i + 1) begin : g_dq_drive
	assign sram_dq[i] = dq_oe_q[i] ? dq_out_q[i] : 1'bz;
end

if (DQ_SYNC_IN != 0) begin : g_dq_sync
	logic [W_DATA-1:0] dq_sync_q;
	always_ff @(posedge clk_sys) begin
		dq_sync_q <= sram_dq;
	end
	assign dq_in = dq_sync_q;
end else begin : g_dq_direct
	assign dq_in = sram_dq;
end
endgenerate

assign sram_addr = addr_q;
assign sram_we_n = we_n_q;
assign sram_oe_n = oe_n_q;
assign sram_ce_n = ce_n_q;
assign sram_byte_n = byte_n_q;

endmodule

`default_nettype wire

/* source/pad_inputs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscboy_defines.svh"

module pad_inputs import board_pkg::*; (
	input  wire         clk_sys,
	input  wire         rst_n,
	input  wire         dpad_u,
	input  wire         dpad_d,
	input  wire         dpad_l,
	input  wire         dpad_r,
	input  wire         btn_a,
	output pad_sample_t pads
);

wire  [`N_PADS-1:0] pad_raw;
logic [`N_PADS-1:0] meta_q;
logic [`N_PADS-1:0] sync_q;

assign pad_raw[`PIN_DPAD_U] = dpad_u;
assign pad_raw[`PIN_DPAD_D] = dpad_d;
assign pad_raw[`PIN_DPAD_L] = dpad_l;
assign pad_raw[`PIN_DPAD_R] = dpad_r;
assign pad_raw[`PIN_BTN_A] = btn_a;

// Two flops per pad
always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		meta_q <= '0;
		sync_q <= '0;
	end else begin
		meta_q <= pad_raw;
		sync_q <= meta_q;
	end
end

assign pads.dpad_u = sync_q[`PIN_DPAD_U];
assign pads.dpad_d = sync_q[`PIN_DPAD_D];
assign pads.dpad_l = sync_q[`PIN_DPAD_L];
assign pads.dpad_r = sync_q[`PIN_DPAD_R];
assign pads.btn_a = sync_q[`PIN_BTN_A];

endmodule

`default_nettype wire

/* source/riscboy_board.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscboy_defines.svh"

module riscboy_board import sram_pkg::*, board_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     rst_n,

	input  wire                     cmd_valid,
	input  wire sram_cmd_t          cmd,
	output wire                     busy,
	output wire                     rsp_valid,
	output wire sram_rsp_t          rsp,

	output wire [`W_SRAM_ADDR-1:0]  sram_addr,
	inout  wire [`W_SRAM_DATA-1:0]  sram_dq,
	output wire                     sram_we_n,
	output wire                     sram_oe_n,
	output wire [`W_SRAM_BYTES-1:0] sram_byte_n,

	input  wire                     dpad_u,
	input  wire                     dpad_d,
	input  wire                     dpad_l,
	input  wire                     dpad_r,
	input  wire                     btn_a,
	output wire [`N_PADS:0]         led
);

localparam DQ_SYNC = 1;
// Pin register stage plus the input synchroniser
localparam SRAM_RD_WAIT = DQ_SYNC + 1;

wire                          sys_rst_n;
wire sram_phy_ctrl_t          phy_ctrl;
wire [`W_SRAM_DATA-1:0]       dq_in;
wire pad_sample_t             pads;

// ########################################################################
// Reset and SRAM path

fpga_reset #(
	.SHIFT (2),
	.COUNT (`RESET_COUNT)
) rstgen (
	.clk_sys     (clk_sys),
	.force_rst_n (rst_n),
	.rst_n       (sys_rst_n)
);

sram_ctrl #(
	.RD_WAIT (SRAM_RD_WAIT)
) sram_ctrl_u (
	.clk_sys   (clk_sys),
	.rst_n     (sys_rst_n),
	.cmd_valid (cmd_valid),
	.cmd       (cmd),
	.busy      (busy),
	.phy_ctrl  (phy_ctrl),
	.dq_in     (dq_in),
	.rsp_valid (rsp_valid),
	.rsp       (rsp)
);

async_sram_phy #(
	.W_ADDR     (`W_SRAM_ADDR),
	.W_DATA     (`W_SRAM_DATA),
	.DQ_SYNC_IN (DQ_SYNC)
) sram_phy_u (
	.clk_sys     (clk_sys),
	.rst_n       (sys_rst_n),
	.ctrl        (phy_ctrl),
	.dq_in       (dq_in),
	.sram_addr   (sram_addr),
	.sram_dq     (sram_dq),
	.sram_we_n   (sram_we_n),
	.sram_oe_n   (sram_oe_n),
	.sram_ce_n   (),
	.sram_byte_n (sram_byte_n)
);

// ########################################################################
// Pads and LEDs

pad_inputs pads_u (
	.clk_sys (clk_sys),
	.rst_n   (sys_rst_n),
	.dpad_u  (dpad_u),
	.dpad_d  (dpad_d),
	.dpad_l  (dpad_l),
	.dpad_r  (dpad_r),
	.btn_a   (btn_a),
	.pads    (pads)
);

assign led = {busy, pads};

endmodule

`default_nettype wire

/* tests/sram_model.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscboy_defines.svh"

module sram_model (
	input  wire [`W_SRAM_ADDR-1:0]  addr,
	inout  wire [`W_SRAM_DATA-1:0]  dq,
	input  wire                     we_n,
	input  wire                     oe_n,
	input  wire [`W_SRAM_BYTES-1:0] byte_n
);

localparam int DEPTH = 1 << `W_SRAM_ADDR;

logic [`W_SRAM_DATA-1:0] mem [DEPTH];
wire  [`W_SRAM_DATA-1:0] rd_word;
wire                     reading;

// Fill depends on every address bit, then writes land on the rising we_n
initial begin
	for (int a = 0; a < DEPTH; a++)
		mem[a] = `W_SRAM_DATA'(a ^ (a >> 2) ^ 32'h0000_a5c3);
	forever begin
		@(posedge we_n);
		if (!$isunknown(addr)) begin
			for (int b = 0; b < `W_SRAM_BYTES; b++) begin
				if (byte_n[b] === 1'b0)
					mem[addr][8*b +: 8] = dq[8*b +: 8];
			end
		end
	end
end

assign reading = (oe_n === 1'b0) && (we_n === 1'b1);
assign rd_word = mem[addr];

genvar b;
generate
for (b = 0; b < `W_SRAM_BYTES; b = b + 1) begin : g_lane
	assign dq[8*b +: 8] = (reading && byte_n[b] === 1'b0) ? rd_word[8*b +: 8] : 8'hzz;
end
endgenerate

endmodule

`default_nettype wire

/* tests/riscboy_properties.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscboy_defines.svh"

module riscboy_properties (
	input wire                    clk_sys,
	input wire                    rst_n,
	input wire                    cmd_valid,
	input wire                    busy,
	input wire                    we_n,
	input wire                    oe_n,
	input wire [`W_SRAM_DATA-1:0] dq_oe
);

we_oe_exclusive: assert property (
	@(posedge clk_sys) disable iff (!rst_n) we_n || oe_n
) else $error("we_n and oe_n are low together");

we_single_cycle: assert property (
	@(posedge clk_sys) disable iff (!rst_n) $fell(we_n) |=> we_n
) else $error("we_n stayed low for more than one cycle");

no_drive_on_read: assert property (
	@(posedge clk_sys) disable iff (!rst_n) !oe_n |-> dq_oe == '0
) else $error("data bus driven while oe_n is low");

cmd_obeys_busy: assert property (
	@(posedge clk_sys) disable iff (!rst_n) busy |-> !cmd_valid
) else $error("cmd_valid strobed while busy is high");

endmodule

// Controller outputs, one cycle ahead of the pins
bind sram_ctrl riscboy_properties ctrl_props (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.cmd_valid (cmd_valid),
	.busy      (busy),
	.we_n      (phy_ctrl.we_n),
	.oe_n      (phy_ctrl.oe_n),
	.dq_oe     (phy_ctrl.dq_oe)
);

// SRAM pins, no command port at this level
bind async_sram_phy riscboy_properties pin_props (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.cmd_valid (1'b0),
	.busy      (1'b0),
	.we_n      (sram_we_n),
	.oe_n      (sram_oe_n),
	.dq_oe     (dq_oe_q)
);

`default_nettype wire

/* tests/tb_riscboy_board.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscboy_defines.svh"

module tb_riscboy_board import sram_pkg::*; ();

localparam int CLK_PERIOD   = 10;
localparam int RESET_CYCLES = 10;
localparam int N_SLOTS      = 256;
localparam int N_PARTIAL    = 128;
localparam int N_RANDOM     = 400;
localparam int N_PAD_CYCLES = 200;
localparam int ACCESS_LIMIT = 20;
localparam int N_ACCESSES   = 2 * N_SLOTS + 2 * N_PARTIAL + N_RANDOM;
// Wait for busy, the strobe cycle and a five cycle read
localparam int WORST_ACCESS = 8;
localparam int TIMEOUT_CYCLES = RESET_CYCLES + `RESET_COUNT + N_ACCESSES * WORST_ACCESS
	+ N_PAD_CYCLES + 500;

logic                     clk_sys;
logic                     rst_n;
logic                     cmd_valid;
sram_cmd_t                cmd;
logic [`N_PADS-1:0]       pad_level;
wire                      busy;
wire                      rsp_valid;
wire sram_rsp_t           rsp;
wire [`W_SRAM_ADDR-1:0]   sram_addr;
wire [`W_SRAM_DATA-1:0]   sram_dq;
wire                      sram_we_n;
wire                      sram_oe_n;
wire [`W_SRAM_BYTES-1:0]  sram_byte_n;
wire [`N_PADS:0]          led;

// Shadow of the SRAM over a random set of addresses
logic [`W_SRAM_ADDR-1:0]  slot_addr [N_SLOTS];
logic [`W_SRAM_DATA-1:0]  slot_data [N_SLOTS];
integer                   seed;

riscboy_board dut0 (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.cmd_valid   (cmd_valid),
	.cmd         (cmd),
	.busy        (busy),
	.rsp_valid   (rsp_valid),
	.rsp         (rsp),
	.sram_addr   (sram_addr),
	.sram_dq     (sram_dq),
	.sram_we_n   (sram_we_n),
	.sram_oe_n   (sram_oe_n),
	.sram_byte_n (sram_byte_n),
	.dpad_u      (pad_level[`PIN_DPAD_U]),
	.dpad_d      (pad_level[`PIN_DPAD_D]),
	.dpad_l      (pad_level[`PIN_DPAD_L]),
	.dpad_r      (pad_level[`PIN_DPAD_R]),
	.btn_a       (pad_level[`PIN_BTN_A]),
	.led         (led)
);

sram_model sram0 (
	.addr   (sram_addr),
	.dq     (sram_dq),
	.we_n   (sram_we_n),
	.oe_n   (sram_oe_n),
	.byte_n (sram_byte_n)
);

initial begin
	clk_sys = 1'b0;
	forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
end

initial begin
	#(TIMEOUT_CYCLES * CLK_PERIOD);
	stop_with_failure("Watchdog expired before all tests had finished");
end

// ##########################################################################
// Helpers

task automatic tick;
	@(posedge clk_sys);
	#1;
endtask

task automatic stop_with_failure(input string why);
	$display("%s", why);
	$display("Result: FAILED");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_equal(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (actual !== expected)
		stop_with_failure($sformatf("Fail %s: expected 0x%0h, actual 0x%0h",
			name, expected, actual));
endtask

// Lanes with byte_n low take the new byte
function automatic logic [`W_SRAM_DATA-1:0] merge_lanes(input logic [`W_SRAM_DATA-1:0] old,
	input logic [`W_SRAM_DATA-1:0] wdata, input logic [`W_SRAM_BYTES-1:0] byte_n);
	logic [`W_SRAM_DATA-1:0] merged;
	merged = old;
	for (int b = 0; b < `W_SRAM_BYTES; b++) begin
		if (!byte_n[b])
			merged[8*b +: 8] = wdata[8*b +: 8];
	end
	return merged;
endfunction

task automatic run_access(input logic write, input int slot,
	input logic [`W_SRAM_DATA-1:0] wdata, input logic [`W_SRAM_BYTES-1:0] byte_n,
	output logic [`W_SRAM_DATA-1:0] rdata);
	int cycles;
	int n_rsp;
	cycles = 0;
	while (busy !== 1'b0) begin
		tick();
		cycles++;
		if (cycles > ACCESS_LIMIT)
			stop_with_failure("busy stayed high while a command was waiting");
	end
	cmd_valid = 1'b1;
	cmd.write = write;
	cmd.addr = slot_addr[slot];
	cmd.wdata = wdata;
	cmd.byte_n = byte_n;
	tick();
	cmd_valid = 1'b0;
	check_equal("busy", 32'd1, 32'(busy));
	cycles = 0;
	n_rsp = 0;
	rdata = '0;
	while (1'b1) begin
		if (rsp_valid === 1'b1) begin
			n_rsp++;
			rdata = rsp.rdata;
		end
		// Address of the command while a strobe is on the pins
		if (sram_we_n === 1'b0 || sram_oe_n === 1'b0)
			check_equal("sram_addr", 32'(slot_addr[slot]), 32'(sram_addr));
		check_equal("led[5]", 32'(busy), 32'(led[`N_PADS]));
		if (busy !== 1'b1)
			break;
		tick();
		cycles++;
		if (cycles > ACCESS_LIMIT)
			stop_with_failure("busy did not fall after a command");
	end
	if (write) begin
		check_equal("write busy cycles", 32'd4, 32'(cycles));
		check_equal("rsp_valid pulses", 32'd0, 32'(n_rsp));
	end else begin
		// The response pulse comes with the falling busy
		check_equal("rsp_valid", 32'd1, 32'(rsp_valid));
		check_equal("rsp_valid pulses", 32'd1, 32'(n_rsp));
	end
endtask

task automatic write_slot(input int slot, input logic [`W_SRAM_DATA-1:0] wdata,
	input logic [`W_SRAM_BYTES-1:0] byte_n);
	logic [`W_SRAM_DATA-1:0] ignored;
	run_access(1'b1, slot, wdata, byte_n, ignored);
	slot_data[slot] = merge_lanes(slot_data[slot], wdata, byte_n);
endtask

task automatic read_slot(input int slot);
	logic [`W_SRAM_DATA-1:0] rdata;
	run_access(1'b0, slot, '0, '0, rdata);
	check_equal($sformatf("rsp.rdata at 0x%0h", slot_addr[slot]),
		32'(slot_data[slot]), 32'(rdata));
endtask

// ##########################################################################
// Test phases

task automatic check_reset_outputs;
	check_equal("busy", 32'd1, 32'(busy));
	check_equal("rsp_valid", 32'd0, 32'(rsp_valid));
	check_equal("sram_we_n", 32'd1, 32'(sram_we_n));
	check_equal("sram_oe_n", 32'd1, 32'(sram_oe_n));
	check_equal("sram_byte_n", 32'h3, 32'(sram_byte_n));
	check_equal("dq_oe_q", 32'd0, 32'(dut0.sram_phy_u.dq_oe_q));
	check_equal("led[4:0]", 32'd0, 32'(led[`N_PADS-1:0]));
	check_equal("led[5]", 32'(busy), 32'(led[`N_PADS]));
endtask

task automatic check_reset_sequence;
	int edges;
	int rel_edge;
	repeat (RESET_CYCLES) begin
		tick();
		check_reset_outputs();
	end
	rst_n = 1'b1;
	edges = 0;
	rel_edge = 0;
	while (busy !== 1'b0) begin
		tick();
		edges++;
		if (edges > `RESET_COUNT + 20)
			stop_with_failure("busy did not fall after the reset was released");
		if (dut0.sys_rst_n === 1'b1) begin
			if (rel_edge == 0)
				rel_edge = edges;
		end else begin
			check_reset_outputs();
		end
	end
	check_equal("sys_rst_n release edge", 32'(`RESET_COUNT + 2), 32'(rel_edge));
	// Controller leaves reset on the edge after sys_rst_n rises
	check_equal("busy release edge", 32'(`RESET_COUNT + 3), 32'(edges));
endtask

task automatic pad_follow;
	logic [`N_PADS-1:0] prev;
	logic [31:0]        r;
	repeat (N_PAD_CYCLES) begin
		prev = pad_level;
		r = $random(seed);
		pad_level = r[`N_PADS-1:0];
		tick();
		// A level applied before edge n is on led after edge n+1
		check_equal("led[4:0]", 32'(prev), 32'(led[`N_PADS-1:0]));
		check_equal("led[5]", 32'(busy), 32'(led[`N_PADS]));
		check_equal("rsp_valid", 32'd0, 32'(rsp_valid));
	end
endtask

initial begin
	logic [31:0] r;
	logic [31:0] w;
	seed = 32'he2b613fb;
	rst_n = 1'b0;
	cmd_valid = 1'b0;
	cmd = '0;
	pad_level = '0;
	// Distinct low bytes keep the slot addresses distinct
	for (int i = 0; i < N_SLOTS; i++) begin
		r = $random(seed);
		slot_addr[i] = {r[`W_SRAM_ADDR-9:0], 8'(i)};
		slot_data[i] = '0;
	end
	check_reset_sequence();
	for (int i = 0; i < N_SLOTS; i++) begin
		w = $random(seed);
		write_slot(i, w[`W_SRAM_DATA-1:0], '0);
		read_slot(i);
	end
	repeat (N_PARTIAL) begin
		r = $random(seed);
		w = $random(seed);
		write_slot(int'(r[7:0]), w[`W_SRAM_DATA-1:0], w[17:16]);
		read_slot(int'(r[7:0]));
	end
	repeat (N_RANDOM) begin
		r = $random(seed);
		w = $random(seed);
		if (r[8])
			write_slot(int'(r[7:0]), w[`W_SRAM_DATA-1:0], w[17:16]);
		else
			read_slot(int'(r[7:0]));
	end
	pad_follow();
	$display("Result: PASSED");
	$finish;
end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/sram_pkg.sv
source/board_pkg.sv
source/fpga_reset.sv
source/sram_ctrl.sv
source/async_sram_phy.sv
source/pad_inputs.sv
source/riscboy_board.sv
tests/sram_model.sv
tests/riscboy_properties.sv
tests/tb_riscboy_board.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	--top-module tb_riscboy_board \
	-f tb.f \
	-o tb_riscboy_board

# A failing run still leaves its log for the search below
./obj_dir/tb_riscboy_board > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
